//--- src/ispe_defines.svh
// --------------------
// Input-side PE widths and depths
// --------------------
`ifndef ISPE_DEFINES_SVH
`define ISPE_DEFINES_SVH

// Operand format
`define ISPE_IN_W         64
`define ISPE_BYTE_W       8

// Dot product and accumulator
`define ISPE_PROD_W       20
`define ISPE_ACC_W        48

// Delay line between multiplier and accumulator
`define ISPE_MUL_STAGES   2

// Radix-4 digits for a 9-bit multiplier
`define ISPE_BOOTH_DIGITS 5

`endif

//--- src/ispe_ctrl_pkg.sv
// --------------------
// Input-side PE control types
// Convert and MAC stage command fields
// --------------------
package ispe_ctrl_pkg;

  // Accumulator shift with value 3 acting as 16
  typedef enum logic [1:0] {
    ACC_SH0  = 2'd0,
    ACC_SH8  = 2'd1,
    ACC_SH16 = 2'd2
  } acc_mode_e;

  // --------------------
  // Convert stage
  typedef struct packed {
    logic cvt_enable;
    logic relu_enable;
    logic zpad_enable;
    logic half_sel;    // 0 takes bytes 0..3, 1 takes bytes 4..7
    logic uint_mode;
  } cvt_ctrl_t;

  // --------------------
  // MAC stage
  typedef struct packed {
    logic      mul_enable;
    logic      acc_enable;
    logic      acc_afresh;  // One-cycle clear
    acc_mode_e acc_mode;
  } mac_ctrl_t;

endpackage

//--- src/ispe_data_pkg.sv
// --------------------
// Input-side PE datapath types
// Lanes, sums, accumulator and Booth digits
// --------------------
`include "ispe_defines.svh"

package ispe_data_pkg;

  // Registered operands of one dot product
  typedef struct packed {
    logic [`ISPE_BYTE_W-1:0] u0;  // Multipliers
    logic [`ISPE_BYTE_W-1:0] u1;
    logic [`ISPE_BYTE_W-1:0] v0;  // Multiplicands
    logic [`ISPE_BYTE_W-1:0] v1;
    logic                    is_uint;
  } lane_set_t;

  // u0*v0 + u1*v1
  typedef logic signed [`ISPE_PROD_W-1:0] prod_t;

  typedef logic signed [`ISPE_ACC_W-1:0] accum_t;

  // --------------------
  // Radix-4 recoded digit
  typedef enum logic [2:0] {
    BD_ZERO = 3'd0,
    BD_P1X  = 3'd1,
    BD_P2X  = 3'd2,
    BD_N1X  = 3'd3,
    BD_N2X  = 3'd4
  } booth_digit_e;

endpackage

//--- src/ispe_convert.sv
// --------------------
// Convert stage that picks a half word and
// clamps byte lanes into the lane register
// --------------------
`timescale 1ns/1ps
`include "ispe_defines.svh"

module ispe_convert
  import ispe_ctrl_pkg::*;
  import ispe_data_pkg::*;
(
  input  logic                  aixh_core_clk2x,
  input  logic                  arst_n,
  input  cvt_ctrl_t             cvt_ctrl,
  input  logic [`ISPE_IN_W-1:0] ixdata,
  output lane_set_t             lanes
);

  logic [`ISPE_IN_W/2-1:0] half_word;
  lane_set_t               lanes_nx;

  // Zero on padding, or on a negative byte under relu
  function automatic logic [`ISPE_BYTE_W-1:0] clamp_lane(
    input logic [`ISPE_BYTE_W-1:0] b,
    input logic                    zpad,
    input logic                    relu
  );
    if (zpad || (relu && b[`ISPE_BYTE_W-1])) begin
      return '0;
    end
    return b;
  endfunction

  assign half_word = cvt_ctrl.half_sel ? ixdata[`ISPE_IN_W-1:`ISPE_IN_W/2]
                                       : ixdata[`ISPE_IN_W/2-1:0];

  // Even bytes feed the multipliers, odd bytes the multiplicands
  always_comb begin
    lanes_nx.u0 = clamp_lane(half_word[0*`ISPE_BYTE_W +: `ISPE_BYTE_W],
                             cvt_ctrl.zpad_enable, cvt_ctrl.relu_enable);
    lanes_nx.v0 = clamp_lane(half_word[1*`ISPE_BYTE_W +: `ISPE_BYTE_W],
                             cvt_ctrl.zpad_enable, cvt_ctrl.relu_enable);
    lanes_nx.u1 = clamp_lane(half_word[2*`ISPE_BYTE_W +: `ISPE_BYTE_W],
                             cvt_ctrl.zpad_enable, cvt_ctrl.relu_enable);
    lanes_nx.v1 = clamp_lane(half_word[3*`ISPE_BYTE_W +: `ISPE_BYTE_W],
                             cvt_ctrl.zpad_enable, cvt_ctrl.relu_enable);
    lanes_nx.is_uint = cvt_ctrl.uint_mode;
  end

  always_ff @(posedge aixh_core_clk2x or negedge arst_n) begin
    if (!arst_n) begin
      lanes <= '0;
    end else if (cvt_ctrl.cvt_enable) begin
      lanes <= lanes_nx;
    end
  end

endmodule

//--- src/ispe_booth_dot.sv
// --------------------
// Radix-4 Booth dot product of two lanes
// --------------------
`timescale 1ns/1ps
`include "ispe_defines.svh"

module ispe_booth_dot
  import ispe_data_pkg::*;
(
  input  lane_set_t lanes,
  output prod_t     sum
);

  logic signed [`ISPE_BYTE_W:0]   mplr [2];  // 9-bit extended multipliers
  logic signed [`ISPE_BYTE_W:0]   mcnd [2];
  logic        [`ISPE_BYTE_W+2:0] rec  [2];  // Multiplier with guard bits
  booth_digit_e                   digit [2][`ISPE_BOOTH_DIGITS];

  function automatic booth_digit_e booth_enc(input logic [2:0] trip);
    case (trip)
      3'b001, 3'b010: return BD_P1X;
      3'b011:         return BD_P2X;
      3'b100:         return BD_N2X;
      3'b101, 3'b110: return BD_N1X;
      default:        return BD_ZERO;
    endcase
  endfunction

  // 0, +-1x or +-2x the multiplicand
  function automatic logic signed [`ISPE_BYTE_W+2:0] booth_pp(
    input booth_digit_e           d,
    input logic signed [`ISPE_BYTE_W:0] md
  );
    logic signed [`ISPE_BYTE_W+2:0] m1;
    logic signed [`ISPE_BYTE_W+2:0] m2;
    m1 = {{2{md[`ISPE_BYTE_W]}}, md};
    m2 = {md[`ISPE_BYTE_W], md, 1'b0};
    case (d)
      BD_P1X:  return m1;
      BD_P2X:  return m2;
      BD_N1X:  return -m1;
      BD_N2X:  return -m2;
      default: return '0;
    endcase
  endfunction

  // Sign extension only in signed mode
  assign mplr[0] = {~lanes.is_uint & lanes.u0[`ISPE_BYTE_W-1], lanes.u0};
  assign mplr[1] = {~lanes.is_uint & lanes.u1[`ISPE_BYTE_W-1], lanes.u1};
  assign mcnd[0] = {~lanes.is_uint & lanes.v0[`ISPE_BYTE_W-1], lanes.v0};
  assign mcnd[1] = {~lanes.is_uint & lanes.v1[`ISPE_BYTE_W-1], lanes.v1};

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      rec[k] = {mplr[k][`ISPE_BYTE_W], mplr[k], 1'b0};
      for (int i = 0; i < `ISPE_BOOTH_DIGITS; i++) begin
        digit[k][i] = booth_enc(rec[k][2*i +: 3]);
      end
    end
  end

  // --------------------
  // Ten weighted partial products
  always_comb begin
    prod_t term;
    sum = '0;
    for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < `ISPE_BOOTH_DIGITS; i++) begin
        term = booth_pp(digit[k][i], mcnd[k]);
        sum  = sum + (term <<< (2*i));
      end
    end
  end

endmodule

//--- src/ispe_prod_pipe.sv
// --------------------
// Enable-gated delay line for dot-product sums
// --------------------
`timescale 1ns/1ps
`include "ispe_defines.svh"

module ispe_prod_pipe
  import ispe_data_pkg::*;
(
  input  logic  aixh_core_clk2x,
  input  logic  arst_n,
  input  logic  mul_enable,
  input  prod_t sum,
  output prod_t prod
);

  // Stages free for retiming into the multiplier
  prod_t stage [`ISPE_MUL_STAGES];

  always_ff @(posedge aixh_core_clk2x or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `ISPE_MUL_STAGES; i++) begin
        stage[i] <= '0;
      end
    end else if (mul_enable) begin
      stage[0] <= sum;
      for (int i = 1; i < `ISPE_MUL_STAGES; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign prod = stage[`ISPE_MUL_STAGES-1];  // Last stage

endmodule

//--- src/ispe_accum.sv
// --------------------
// 48-bit accumulator with shift and clear
// --------------------
`timescale 1ns/1ps

module ispe_accum
  import ispe_ctrl_pkg::*;
  import ispe_data_pkg::*;
(
  input  logic      aixh_core_clk2x,
  input  logic      arst_n,
  input  logic      acc_enable,
  input  logic      acc_afresh,
  input  acc_mode_e acc_mode,
  input  prod_t     prod,
  output accum_t    acc
);

  accum_t prod_ext;
  accum_t addend;

  assign prod_ext = prod;  // Sign extension

  always_comb begin
    case (acc_mode)
      ACC_SH0: addend = prod_ext;
      ACC_SH8: addend = prod_ext <<< 8;
      default: addend = prod_ext <<< 16;  // Value 3 too
    endcase
  end

  // Clear wins over accumulate and overflow wraps
  always_ff @(posedge aixh_core_clk2x or negedge arst_n) begin
    if (!arst_n) begin
      acc <= '0;
    end else if (acc_afresh) begin
      acc <= '0;
    end else if (acc_enable) begin
      acc <= acc + addend;
    end
  end

endmodule

//--- src/ispe_top.sv
// --------------------
// Input-side PE top level
// Convert, Booth dot product, delay line, accumulator
// --------------------
`timescale 1ns/1ps
`include "ispe_defines.svh"

module ispe_top
  import ispe_ctrl_pkg::*;
  import ispe_data_pkg::*;
(
  input  logic                  aixh_core_clk2x,
  input  logic                  arst_n,
  input  cvt_ctrl_t             cvt_ctrl,
  input  mac_ctrl_t             mac_ctrl,
  input  logic [`ISPE_IN_W-1:0] ixdata,
  output lane_set_t             oxdata,
  output accum_t                ozdata
);

  lane_set_t lanes;
  prod_t     sum;
  prod_t     prod;

  // --------------------
  // MAC control fields
  logic      mul_enable;
  logic      acc_enable;
  logic      acc_afresh;
  acc_mode_e acc_mode;

  assign mul_enable = mac_ctrl.mul_enable;
  assign acc_enable = mac_ctrl.acc_enable;
  assign acc_afresh = mac_ctrl.acc_afresh;
  assign acc_mode   = mac_ctrl.acc_mode;

  ispe_convert u_convert (
    .aixh_core_clk2x (aixh_core_clk2x),
    .arst_n          (arst_n),
    .cvt_ctrl        (cvt_ctrl),
    .ixdata          (ixdata),
    .lanes           (lanes)
  );

  ispe_booth_dot u_booth_dot (
    .lanes (lanes),
    .sum   (sum)
  );

  ispe_prod_pipe u_prod_pipe (
    .aixh_core_clk2x (aixh_core_clk2x),
    .arst_n          (arst_n),
    .mul_enable      (mul_enable),
    .sum             (sum),
    .prod            (prod)
  );

  ispe_accum u_accum (
    .aixh_core_clk2x (aixh_core_clk2x),
    .arst_n          (arst_n),
    .acc_enable      (acc_enable),
    .acc_afresh      (acc_afresh),
    .acc_mode        (acc_mode),
    .prod            (prod),
    .acc             (ozdata)
  );

  assign oxdata = lanes;  // Registered lanes out

endmodule

//--- test/ispe_props.sv
// --------------------
// Input-side PE properties bound to the top level
// --------------------
`timescale 1ns/1ps

module ispe_props
  import ispe_ctrl_pkg::*;
  import ispe_data_pkg::*;
(
  input logic      aixh_core_clk2x,
  input logic      arst_n,
  input cvt_ctrl_t cvt_ctrl,
  input mac_ctrl_t mac_ctrl,
  input lane_set_t oxdata,
  input accum_t    ozdata
);

  // Clear empties the accumulator
  afresh_clears: assert property (@(posedge aixh_core_clk2x) disable iff (!arst_n)
    mac_ctrl.acc_afresh |=> (ozdata == '0))
    else $error("accumulator not zero after clear");

  lanes_hold: assert property (@(posedge aixh_core_clk2x) disable iff (!arst_n)
    !cvt_ctrl.cvt_enable |=> $stable(oxdata))
    else $error("lane register changed without cvt_enable");

  // No clear and no enable, so no change
  acc_hold: assert property (@(posedge aixh_core_clk2x) disable iff (!arst_n)
    (!mac_ctrl.acc_afresh && !mac_ctrl.acc_enable) |=> $stable(ozdata))
    else $error("accumulator changed while idle");

endmodule

bind ispe_top ispe_props props_i (
  .aixh_core_clk2x (aixh_core_clk2x),
  .arst_n          (arst_n),
  .cvt_ctrl        (cvt_ctrl),
  .mac_ctrl        (mac_ctrl),
  .oxdata          (oxdata),
  .ozdata          (ozdata)
);

//--- test/ispe_tb.sv
// --------------------
// Input-side PE testbench
// Random stimulus checked against a cycle model
// --------------------
`timescale 1ns/1ps
`include "ispe_defines.svh"

module ispe_tb
  import ispe_ctrl_pkg::*;
  import ispe_data_pkg::*;
;

  localparam int PHASE_CYCLES   = 600;
  localparam int NUM_PHASES     = 4;
  localparam int TIMEOUT_CYCLES = 3000;  // Above 4 x 600 plus reset

  logic                  aixh_core_clk2x;
  logic                  arst_n;
  cvt_ctrl_t             cvt_ctrl;
  mac_ctrl_t             mac_ctrl;
  logic [`ISPE_IN_W-1:0] ixdata;
  lane_set_t             oxdata;
  accum_t                ozdata;

  // Model state
  lane_set_t m_lanes;
  prod_t     m_pipe [`ISPE_MUL_STAGES];
  accum_t    m_acc;
  int        err_count   = 0;
  int        cycle_count = 0;

  ispe_top dut_i (
    .aixh_core_clk2x (aixh_core_clk2x),
    .arst_n          (arst_n),
    .cvt_ctrl        (cvt_ctrl),
    .mac_ctrl        (mac_ctrl),
    .ixdata          (ixdata),
    .oxdata          (oxdata),
    .ozdata          (ozdata)
  );

  always #20 aixh_core_clk2x = ~aixh_core_clk2x;

  // --------------------
  // Reference functions
  function automatic lane_set_t lane_ref(input logic [63:0] d, input cvt_ctrl_t c);
    lane_set_t  r;
    logic [7:0] b [4];
    for (int i = 0; i < 4; i++) begin
      b[i] = c.half_sel ? d[32 + 8*i +: 8] : d[8*i +: 8];
      if (c.zpad_enable || (c.relu_enable && b[i][7])) begin
        b[i] = 8'h00;
      end
    end
    r.u0      = b[0];
    r.v0      = b[1];
    r.u1      = b[2];
    r.v1      = b[3];
    r.is_uint = c.uint_mode;
    return r;
  endfunction

  function automatic prod_t dot_ref(input lane_set_t l);
    int a0;
    int a1;
    int b0;
    int b1;
    if (l.is_uint) begin
      a0 = l.u0;
      a1 = l.u1;
      b0 = l.v0;
      b1 = l.v1;
    end else begin
      a0 = $signed(l.u0);
      a1 = $signed(l.u1);
      b0 = $signed(l.v0);
      b1 = $signed(l.v1);
    end
    return prod_t'(a0 * b0 + a1 * b1);
  endfunction

  function automatic accum_t shift_ref(input prod_t p, input logic [1:0] mode);
    longint wide;
    wide = p;
    if (mode == 2'd1) begin
      wide = wide <<< 8;
    end else if (mode[1]) begin
      wide = wide <<< 16;  // Modes 2 and 3
    end
    return wide[`ISPE_ACC_W-1:0];
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // --------------------
  // One stimulus phase per behavior group
  task automatic drive_phase(input int phase);
    cvt_ctrl_t   c;
    mac_ctrl_t   m;
    logic [63:0] d;
    for (int n = 0; n < PHASE_CYCLES; n++) begin
      d = {$urandom, $urandom};
      c = '0;
      m = '0;
      c.cvt_enable = 1'b1;
      c.half_sel   = $urandom_range(1, 0);
      c.uint_mode  = (phase == 1);
      m.mul_enable = 1'b1;
      m.acc_enable = 1'b1;
      m.acc_mode   = ACC_SH0;
      case (phase)
        1: if ($urandom_range(7, 0) == 0) d = '1;  // All-ones bytes
        2: begin
          c.zpad_enable = ($urandom_range(3, 0) == 0);
          c.relu_enable = $urandom_range(1, 0);
          c.uint_mode   = $urandom_range(1, 0);
        end
        3: begin
          c.uint_mode  = $urandom_range(1, 0);
          c.cvt_enable = ($urandom_range(3, 0) != 0);
          m.mul_enable = ($urandom_range(3, 0) != 0);
          m.acc_enable = ($urandom_range(3, 0) != 0);
          m.acc_afresh = ($urandom_range(15, 0) == 0);
          m.acc_mode   = acc_mode_e'(2'($urandom_range(3, 0)));
        end
        default: ;
      endcase
      @(posedge aixh_core_clk2x);
      cvt_ctrl <= c;
      mac_ctrl <= m;
      ixdata   <= d;
    end
  endtask

  initial begin
    void'($urandom(32'hf8af));
    aixh_core_clk2x = 1'b0;
    arst_n          = 1'b0;
    cvt_ctrl        = '0;
    mac_ctrl        = '0;
    ixdata          = '0;
    repeat (16) @(posedge aixh_core_clk2x);
    arst_n <= 1'b1;
    for (int p = 0; p < NUM_PHASES; p++) begin
      drive_phase(p);
    end
    repeat (4) @(posedge aixh_core_clk2x);
    if (err_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("TB FAILED");
      $fatal(1, "checks failed");
    end
  end

  // --------------------
  // Cycle model on the inputs seen by this edge
  always @(posedge aixh_core_clk2x) begin
    if (!arst_n) begin
      m_lanes = '0;
      m_acc   = '0;
      for (int i = 0; i < `ISPE_MUL_STAGES; i++) begin
        m_pipe[i] = '0;
      end
    end else begin
      if (mac_ctrl.acc_afresh) begin
        m_acc = '0;
      end else if (mac_ctrl.acc_enable) begin
        m_acc = m_acc + shift_ref(m_pipe[`ISPE_MUL_STAGES-1], mac_ctrl.acc_mode);
      end
      if (mac_ctrl.mul_enable) begin
        for (int i = `ISPE_MUL_STAGES - 1; i > 0; i--) begin
          m_pipe[i] = m_pipe[i-1];
        end
        m_pipe[0] = dot_ref(m_lanes);
      end
      if (cvt_ctrl.cvt_enable) begin
        m_lanes = lane_ref(ixdata, cvt_ctrl);
      end
    end
  end

  // Outputs are settled by the falling edge
  always @(negedge aixh_core_clk2x) begin
    if (arst_n) begin
      check_value("oxdata", oxdata, m_lanes);
      check_value("ozdata", ozdata, m_acc);
    end
  end

  always @(posedge aixh_core_clk2x) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $fatal(1, "stopped by cycle limit");
    end
  end

endmodule

//--- list.f
+incdir+src
src/ispe_ctrl_pkg.sv
src/ispe_data_pkg.sv
src/ispe_convert.sv
src/ispe_booth_dot.sv
src/ispe_prod_pipe.sv
src/ispe_accum.sv
src/ispe_top.sv
test/ispe_props.sv
test/ispe_tb.sv

//--- Bender.yml
package:
  name: ispe

sources:
  - include_dirs:
      - src
    files:
      - src/ispe_ctrl_pkg.sv
      - src/ispe_data_pkg.sv
      - src/ispe_convert.sv
      - src/ispe_booth_dot.sv
      - src/ispe_prod_pipe.sv
      - src/ispe_accum.sv
      - src/ispe_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - test/ispe_props.sv
      - test/ispe_tb.sv
